/* src/rv_pkg.sv */
// ====================
// Shared core definitions
// Widths, major opcodes and funct codes
// ALU operation enum and instruction union
// ====================

package rv_pkg;

  // ====================
  // Widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // Major opcodes kept by this core
  localparam logic [6:0] opc_op     = 7'b0110011;  // R-type ALU
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // I-type ALU
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // funct3 codes, shared by R and I forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] funct7_alt = 7'b0100000;  // SUB select

  // ====================
  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b  // LUI result
  } alu_op_e;

  // Instruction field views, MSB first
  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fields_t;

  typedef struct packed {
    logic [19:0]           imm20;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fields_t;

  // Same 32-bit word, view picked by opcode
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    u_fields_t u;
  } instr_u;

endpackage

/* src/rv_issue_if.sv */
// ====================
// Issue packet from decode to execute
// ====================

`timescale 1ns/1ps

interface rv_issue_if;
  import rv_pkg::*;

  logic                  valid;     // Packet present, no ready
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0]       rs1_data;  // Already bypassed from regfile
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       imm;
  alu_op_e               alu_op;
  logic                  use_imm;   // Operand B from imm
  logic                  is_lui;    // Operand A forced to zero

  modport src (output valid, rd, rs1, rs2, rs1_data, rs2_data,
               output imm, alu_op, use_imm, is_lui);
  modport dst (input valid, rd, rs1, rs2, rs1_data, rs2_data,
               input imm, alu_op, use_imm, is_lui);

endinterface

/* src/rv_regfile.sv */
// ====================
// Integer register file
// x0 reads zero, write-through bypass on read
// ====================

`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          wr_en,
  input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv_pkg::xlen-1:0]       wr_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [1:num_regs-1];  // No storage for x0

  // Write port, clears all on reset
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Read ports
  // Same-cycle write wins so decode sees the value one edge early
  assign rs1_data = (rs1_addr == '0)                   ? '0 :
                    (wr_en && (wr_addr == rs1_addr))   ? wr_data :
                                                         regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0)                   ? '0 :
                    (wr_en && (wr_addr == rs2_addr))   ? wr_data :
                                                         regs[rs2_addr];

  // Decode drops rd == x0 packets, so no write should target x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (!reset_n)
    wr_en |-> (wr_addr != '0));

endmodule

/* src/rv_decode_stage.sv */
// ====================
// Decode stage
// Field decode, immediates, operand read
// ID/EX pipeline register
// ====================

`timescale 1ns/1ps

module rv_decode_stage (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          instr_valid,
  input  rv_pkg::instr_u                instr,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::xlen-1:0]       rs1_data,
  input  logic [rv_pkg::xlen-1:0]       rs2_data,
  rv_issue_if.src                       issue
);
  import rv_pkg::*;

  logic                  supported;  // Opcode and funct known
  logic [reg_addr_w-1:0] dec_rd;
  logic [xlen-1:0]       dec_imm;
  alu_op_e               dec_alu_op;
  logic                  dec_use_imm;
  logic                  dec_is_lui;

  // ====================
  // Combinational decode
  always_comb begin
    supported   = 1'b0;
    dec_rd      = instr.r.rd;
    rs1_addr    = instr.r.rs1;   // Garbage for LUI, ignored in EX
    rs2_addr    = instr.r.rs2;
    dec_imm     = '0;
    dec_alu_op  = alu_add;
    dec_use_imm = 1'b0;
    dec_is_lui  = 1'b0;
    case (instr.r.opcode)
      opc_op: begin
        // Only funct7 zero, or SUB with the alt bit
        supported = (instr.r.funct7 == '0) ||
                    ((instr.r.funct7 == funct7_alt) && (instr.r.funct3 == f3_add_sub));
        case (instr.r.funct3)
          f3_add_sub: dec_alu_op = (instr.r.funct7 == funct7_alt) ? alu_sub : alu_add;
          f3_sll:     dec_alu_op = alu_sll;
          f3_slt:     dec_alu_op = alu_slt;
          f3_xor:     dec_alu_op = alu_xor;
          f3_srl:     dec_alu_op = alu_srl;
          f3_or:      dec_alu_op = alu_or;
          f3_and:     dec_alu_op = alu_and;
          default:    supported  = 1'b0;  // SLTU not kept
        endcase
      end
      opc_op_imm: begin
        supported   = 1'b1;
        dec_use_imm = 1'b1;
        dec_imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};  // Sign extend
        case (instr.i.funct3)
          f3_add_sub: dec_alu_op = alu_add;
          f3_slt:     dec_alu_op = alu_slt;
          f3_xor:     dec_alu_op = alu_xor;
          f3_or:      dec_alu_op = alu_or;
          f3_and:     dec_alu_op = alu_and;
          default:    supported  = 1'b0;  // Shift imm, SLTIU
        endcase
      end
      opc_lui: begin
        supported   = 1'b1;
        dec_use_imm = 1'b1;
        dec_is_lui  = 1'b1;
        dec_alu_op  = alu_pass_b;
        dec_imm     = {instr.u.imm20, {(xlen-20){1'b0}}};  // Upper 20 bits
      end
      default: supported = 1'b0;  // Bubble
    endcase
  end

  // ====================
  // ID/EX register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= instr_valid && supported && (dec_rd != '0);  // rd x0 is a bubble
    end
  end

  always_ff @(posedge clk) begin
    issue.rd       <= dec_rd;
    issue.rs1      <= rs1_addr;
    issue.rs2      <= rs2_addr;
    issue.rs1_data <= rs1_data;
    issue.rs2_data <= rs2_data;
    issue.imm      <= dec_imm;
    issue.alu_op   <= dec_alu_op;
    issue.use_imm  <= dec_use_imm;
    issue.is_lui   <= dec_is_lui;
  end

  a_instr_known: assert property (@(posedge clk) disable iff (!reset_n)
    instr_valid |-> !$isunknown(instr));

endmodule

/* src/rv_execute_stage.sv */
// ====================
// Execute stage
// EX/WB forwarding, ALU
// EX/WB register driving write-back
// ====================

`timescale 1ns/1ps

module rv_execute_stage (
  input  logic                          clk,
  input  logic                          reset_n,
  rv_issue_if.dst                       issue,
  output logic                          wr_en,
  output logic [rv_pkg::reg_addr_w-1:0] wr_addr,
  output logic [rv_pkg::xlen-1:0]       wr_data
);
  import rv_pkg::*;

  localparam int shamt_w = $clog2(xlen);

  logic            fwd_a;       // rs1 hits EX/WB
  logic            fwd_b;       // rs2 hits EX/WB
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;

  // ====================
  // Forwarding from EX/WB
  // Distance-2 hazards are covered by the regfile bypass
  assign fwd_a = wr_en && (wr_addr == issue.rs1);
  assign fwd_b = wr_en && (wr_addr == issue.rs2);

  // LUI rs1 field is not a register, keep A at zero
  assign op_a = issue.is_lui ? '0 :
                fwd_a        ? wr_data :
                               issue.rs1_data;

  assign rs2_val = fwd_b ? wr_data : issue.rs2_data;
  assign op_b    = issue.use_imm ? issue.imm : rs2_val;

  // ====================
  // ALU
  always_comb begin
    case (issue.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_or:     alu_result = op_a | op_b;
      alu_xor:    alu_result = op_a ^ op_b;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      alu_sll:    alu_result = op_a << op_b[shamt_w-1:0];   // Low 5 bits only
      alu_srl:    alu_result = op_a >> op_b[shamt_w-1:0];
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // ====================
  // EX/WB register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= issue.rd;
    wr_data <= alu_result;
  end

  // A valid packet never names x0 as destination
  a_wb_not_x0: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(wr_en) |-> (wr_addr != '0));

endmodule

/* src/rv_mini_core.sv */
// ====================
// RV32I mini core top
// Decode, register file and execute
// ====================

`timescale 1ns/1ps

module rv_mini_core (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          instr_valid,
  input  logic [31:0]                   instr,
  output logic                          wb_valid,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data
);
  import rv_pkg::*;

  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  rv_issue_if issue_if ();  // ID/EX packet

  rv_decode_stage decode_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue       (issue_if.src)
  );

  // Write-back port doubles as the top-level report
  rv_regfile regfile_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_valid),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data)
  );

  rv_execute_stage execute_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .issue   (issue_if.dst),
    .wr_en   (wb_valid),
    .wr_addr (wb_rd),
    .wr_data (wb_data)
  );

endmodule

/* dv/rv_clock_gen.sv */
// ====================
// Testbench clock and reset
// 100 ns period, reset low for 8 cycles
// ====================

`timescale 1ns/1ps

module rv_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // Half of the 100 ns period
  end

  // Release on a falling edge, after the testbench samples it
  initial begin
    reset_n = 1'b0;
    repeat (8) @(negedge clk);
    reset_n <= 1'b1;
  end

endmodule

/* dv/rv_mini_core_tb.sv */
// ====================
// Testbench for the RV32I mini core
// Instruction table with expected write-back
// Compare task, per-test report, bounded waits
// ====================

`timescale 1ns/1ps

module rv_mini_core_tb;

  localparam int reset_limit = 20;  // Cycles allowed for reset release
  localparam int drain_limit = 10;  // Cycles allowed for the pipeline to empty
  localparam int idle_cycles = 2;

  // One instruction and the write-back it must produce
  typedef struct packed {
    logic [31:0] instr;
    logic        exp_valid;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
  } row_t;

  logic        clk;
  logic        reset_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  row_t rows[$];
  int   error_count;
  int   test_count;
  int   fail_count;
  bit   timed_out;

  rv_clock_gen clock_gen_inst (.clk(clk), .reset_n(reset_n));

  rv_mini_core rv_mini_core_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  // ====================
  // RV32I encodings
  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};  // OP-IMM
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic v, input logic [4:0] rd,
                         input logic [31:0] data);
    rows.push_back({word, v, rd, data});
  endtask

  // Expected values worked out by hand from the ISA
  task automatic build_table;
    add_row(r_type_word(7'h00, 5'd7, 5'd6, 3'b000, 5'd5), 1'b1, 5'd5, 32'h0);  // ADD, unwritten regs
    add_row(i_type_word(12'hffb, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'hffff_fffb);  // ADDI -5
    add_row(i_type_word(12'h123, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'h0000_0123);
    add_row(lui_word(20'h80010, 5'd3), 1'b1, 5'd3, 32'h8001_0000);  // rs1 field aliases x2
    add_row(i_type_word(12'hff0, 5'd2, 3'b111, 5'd4), 1'b1, 5'd4, 32'h0000_0120);  // ANDI
    add_row(i_type_word(12'hfff, 5'd1, 3'b100, 5'd6), 1'b1, 5'd6, 32'h0000_0004);  // XORI -1
    add_row(i_type_word(12'hf00, 5'd2, 3'b110, 5'd7), 1'b1, 5'd7, 32'hffff_ff23);  // ORI
    add_row(i_type_word(12'hffc, 5'd1, 3'b010, 5'd8), 1'b1, 5'd8, 32'h1);  // SLTI -5 < -4
    add_row(i_type_word(12'hffa, 5'd1, 3'b010, 5'd9), 1'b1, 5'd9, 32'h0);  // SLTI -5 < -6
    add_row(r_type_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd10), 1'b1, 5'd10, 32'h8001_0123);
    add_row(r_type_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd11), 1'b1, 5'd11, 32'h0000_0128);  // SUB
    add_row(r_type_word(7'h00, 5'd7, 5'd3, 3'b111, 5'd12), 1'b1, 5'd12, 32'h8001_0000);
    add_row(r_type_word(7'h00, 5'd3, 5'd2, 3'b110, 5'd13), 1'b1, 5'd13, 32'h8001_0123);
    add_row(r_type_word(7'h00, 5'd7, 5'd1, 3'b100, 5'd14), 1'b1, 5'd14, 32'h0000_00d8);
    add_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd15), 1'b1, 5'd15, 32'h1);  // SLT signed
    add_row(r_type_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd16), 1'b1, 5'd16, 32'h0);
    add_row(r_type_word(7'h00, 5'd6, 5'd2, 3'b001, 5'd17), 1'b1, 5'd17, 32'h0000_1230);  // SLL 4
    add_row(r_type_word(7'h00, 5'd6, 5'd3, 3'b101, 5'd18), 1'b1, 5'd18, 32'h0800_1000);  // SRL 4
    // Dependency chain
    add_row(i_type_word(12'h007, 5'd0, 3'b000, 5'd20), 1'b1, 5'd20, 32'h7);
    add_row(i_type_word(12'h001, 5'd20, 3'b000, 5'd20), 1'b1, 5'd20, 32'h8);  // Distance 1
    add_row(r_type_word(7'h00, 5'd20, 5'd20, 3'b000, 5'd21), 1'b1, 5'd21, 32'h10);
    add_row(i_type_word(12'h003, 5'd0, 3'b000, 5'd22), 1'b1, 5'd22, 32'h3);
    add_row(r_type_word(7'h20, 5'd20, 5'd21, 3'b000, 5'd23), 1'b1, 5'd23, 32'h8);  // x21 at 2
    add_row(r_type_word(7'h00, 5'd22, 5'd23, 3'b001, 5'd24), 1'b1, 5'd24, 32'h40);
    // No write-back expected
    add_row(i_type_word(12'h005, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0);  // rd x0
    add_row(32'h0000_ac83, 1'b0, 5'd0, 32'h0);  // LW x25, not supported
    add_row(r_type_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd26), 1'b1, 5'd26, 32'h0);  // x0 still 0
    add_row(r_type_word(7'h00, 5'd0, 5'd25, 3'b000, 5'd27), 1'b1, 5'd27, 32'h0);  // x25 untouched
  endtask

  // ====================
  // Checking and reporting
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before && !timed_out) begin
      $display("Test %s: pass", name);
    end else begin
      fail_count++;
      $display("Test %s: FAIL", name);
    end
  endtask

  task automatic check_row(input int idx);
    int errors_before;
    errors_before = error_count;
    check_value($sformatf("row %0d wb_valid", idx), {31'b0, wb_valid},
                {31'b0, rows[idx].exp_valid});
    if (rows[idx].exp_valid) begin
      check_value($sformatf("row %0d wb_rd", idx), {27'b0, wb_rd}, {27'b0, rows[idx].exp_rd});
      check_value($sformatf("row %0d wb_data", idx), wb_data, rows[idx].exp_data);
    end
    report_test($sformatf("row %0d", idx), errors_before);
  endtask

  // ====================
  // Test phases
  task automatic check_reset;
    int errors_before;
    int cycles;
    errors_before = error_count;
    cycles = 0;
    while (reset_n !== 1'b1 && cycles < reset_limit) begin
      @(negedge clk);
      check_value("wb_valid during reset", {31'b0, wb_valid}, 32'h0);
      cycles++;
    end
    if (reset_n !== 1'b1) begin
      $display("Timeout: reset still asserted after %0d cycles", reset_limit);
      timed_out = 1'b1;
    end else begin
      repeat (idle_cycles) begin
        @(negedge clk);
        check_value("wb_valid idle after reset", {31'b0, wb_valid}, 32'h0);
      end
    end
    report_test("reset", errors_before);
  endtask

  // Check lags drive by the two-edge latency
  task automatic run_table;
    for (int c = 0; c < rows.size() + 2; c++) begin
      @(negedge clk);
      if (c >= 2) check_row(c - 2);
      if (c < rows.size()) begin
        instr_valid = 1'b1;
        instr       = rows[c].instr;
      end else begin
        instr_valid = 1'b0;
        instr       = '0;
      end
    end
  endtask

  task automatic wait_drain;
    int errors_before;
    int cycles;
    errors_before = error_count;
    cycles = 0;
    while (wb_valid !== 1'b0 && cycles < drain_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (wb_valid !== 1'b0) begin
      $display("Timeout: write-back still active %0d cycles after the last row", drain_limit);
      timed_out = 1'b1;
    end
    report_test("drain", errors_before);
  endtask

  // ====================
  // Main sequence
  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    error_count = 0;
    test_count  = 0;
    fail_count  = 0;
    timed_out   = 1'b0;
    build_table();
    check_reset();
    if (!timed_out) run_table();
    if (!timed_out) wait_drain();
    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

/* rv_mini_core.f */
src/rv_pkg.sv
src/rv_issue_if.sv
src/rv_regfile.sv
src/rv_decode_stage.sv
src/rv_execute_stage.sv
src/rv_mini_core.sv
dv/rv_clock_gen.sv
dv/rv_mini_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the rv_mini_core testbench with Verilator
set -o pipefail

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 \
  -f rv_mini_core.f --top-module rv_mini_core_tb -o rv_mini_core_sim \
  && ./obj_dir/rv_mini_core_sim 2>&1 | tee "$log" \
  || { echo "Build or simulation run did not complete"; exit 1; }

# Verdict comes from the log
grep -qF '*** FAILED ***' "$log" \
  && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }
